/* Bender.yml */
package:
  name: mips_cpu_bus

export_include_dirs:
  - hdl

sources:
  - hdl/mipsPkg.sv
  - hdl/mipsExecIf.sv
  - hdl/mipsRegFile.sv
  - hdl/mipsExecute.sv
  - hdl/mipsControl.sv
  - hdl/mipsCpuBus.sv
  - target: test
    files:
      - verification/mipsCpuBus_assertions.sv
      - verification/mipsCpuBusTb.sv

/* hdl/mipsControl.sv */
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsControl (
    input  logic              clk,
    input  logic              reset,
    mipsExecIf.control        exec,
    output mipsPkg::regAddrT  rsAddr,
    output mipsPkg::regAddrT  rtAddr,
    input  mipsPkg::wordT     rsData,
    input  mipsPkg::wordT     rtData,
    output logic              regWrite,
    output mipsPkg::regAddrT  regWriteAddr,
    output mipsPkg::wordT     regWriteData,
    output logic              active,
    output mipsPkg::wordT     address,
    output logic              write,
    output logic              read,
    input  logic              waitrequest,
    output mipsPkg::wordT     writedata,
    output logic [`MIPS_WORD_W/8-1:0] byteenable,
    input  mipsPkg::wordT     readdata
);
    import mipsPkg::*;

    cpuStateT state;
    wordT     pc;
    wordT     pendingTarget;
    logic     pendingValid;
    instrT    ir;
    wordT     rsVal;
    wordT     rtVal;
    wordT     aluOut;
    wordT     loadData;

    logic isLoad;
    logic isStore;
    logic isBranch;
    logic isJump;
    wordT nextPc;
    logic haltNext;

    // Bus words arrive byte-reversed
    function automatic wordT byteSwap(input wordT w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // Instruction class
    assign isLoad   = ir.i.opcode == OP_LW;
    assign isStore  = ir.i.opcode == OP_SW;
    assign isBranch = (ir.i.opcode == OP_BEQ) || (ir.i.opcode == OP_BNE);
    assign isJump   = (ir.i.opcode == OP_J) ||
                      ((ir.r.opcode == OP_SPECIAL) && (ir.r.funct == FN_JR));

    // Delay slot done means the recorded target comes next
    assign nextPc   = pendingValid ? pendingTarget : pc + 32'd4;
    assign haltNext = pendingValid && (pendingTarget == `MIPS_HALT_ADDR);

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= FETCH;
            pc           <= `MIPS_RESET_VECTOR;
            pendingValid <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (!waitrequest) begin
                        state <= DECODE;
                    end
                end
                DECODE: state <= EXECUTE;
                EXECUTE: begin
                    if (isLoad || isStore) begin
                        state <= MEMORY;
                    end else if (isBranch || isJump) begin
                        state        <= haltNext ? HALTED : FETCH;
                        pc           <= nextPc;
                        pendingValid <= exec.branchTaken;
                    end else begin
                        state <= WRITEBACK;
                    end
                end
                MEMORY: begin
                    if (!waitrequest) begin
                        if (isStore) begin
                            state        <= haltNext ? HALTED : FETCH;
                            pc           <= nextPc;
                            pendingValid <= 1'b0;
                        end else begin
                            state <= WRITEBACK;
                        end
                    end
                end
                WRITEBACK: begin
                    state        <= haltNext ? HALTED : FETCH;
                    pc           <= nextPc;
                    pendingValid <= 1'b0;
                end
                default: state <= HALTED;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH && !waitrequest) begin
            ir <= byteSwap(readdata);
        end
        if (state == DECODE) begin
            rsVal <= rsData;
            rtVal <= rtData;
        end
        if (state == EXECUTE) begin
            aluOut <= exec.result;
            if (isBranch || isJump) begin
                pendingTarget <= exec.target;
            end
        end
        if (state == MEMORY && !waitrequest) begin
            loadData <= readdata;
        end
    end

    assign exec.instr   = ir;
    assign exec.pc      = pc;
    assign exec.rsValue = rsVal;
    assign exec.rtValue = rtVal;

    assign rsAddr = ir.r.rs;
    assign rtAddr = ir.r.rt;

    // R-type writes rd, immediates and loads write rt
    assign regWrite     = state == WRITEBACK;
    assign regWriteAddr = (ir.r.opcode == OP_SPECIAL) ? ir.r.rd : ir.r.rt;
    assign regWriteData = isLoad ? byteSwap(loadData) : aluOut;

    // Strobes held until waitrequest drops
    assign read       = (state == FETCH) || (state == MEMORY && isLoad);
    assign write      = (state == MEMORY) && isStore;
    assign address    = (state == MEMORY) ? aluOut : pc;
    assign writedata  = byteSwap(rtVal);
    assign byteenable = '1;
    assign active     = state != HALTED;

endmodule

/* hdl/mipsCpuBus.sv */
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsCpuBus (
    input  logic          clk,
    input  logic          reset,
    output logic          active,
    output mipsPkg::wordT registerV0,

    // Avalon master
    output mipsPkg::wordT address,
    output logic          write,
    output logic          read,
    input  logic          waitrequest,
    output mipsPkg::wordT writedata,
    output logic [`MIPS_WORD_W/8-1:0] byteenable,
    input  mipsPkg::wordT readdata
);
    import mipsPkg::*;

    regAddrT rsAddr;
    regAddrT rtAddr;
    wordT    rsData;
    wordT    rtData;
    logic    regWrite;
    regAddrT regWriteAddr;
    wordT    regWriteData;

    mipsExecIf execBus ();

    mipsControl control (
        .clk          (clk),
        .reset        (reset),
        .exec         (execBus.control),
        .rsAddr       (rsAddr),
        .rtAddr       (rtAddr),
        .rsData       (rsData),
        .rtData       (rtData),
        .regWrite     (regWrite),
        .regWriteAddr (regWriteAddr),
        .regWriteData (regWriteData),
        .active       (active),
        .address      (address),
        .write        (write),
        .read         (read),
        .waitrequest  (waitrequest),
        .writedata    (writedata),
        .byteenable   (byteenable),
        .readdata     (readdata)
    );

    mipsRegFile regFile (
        .clk        (clk),
        .reset      (reset),
        .rsAddr     (rsAddr),
        .rtAddr     (rtAddr),
        .rsData     (rsData),
        .rtData     (rtData),
        .writeEn    (regWrite),
        .writeAddr  (regWriteAddr),
        .writeData  (regWriteData),
        .registerV0 (registerV0)
    );

    mipsExecute execute (
        .exec (execBus.execute)
    );

endmodule

/* hdl/mipsExecIf.sv */
`timescale 1ns/1ps

interface mipsExecIf;
    import mipsPkg::*;

    // Operands from the sequencer
    instrT instr;
    wordT  pc;
    wordT  rsValue;
    wordT  rtValue;

    // Combinational results back from the execute unit
    wordT  result;
    logic  branchTaken;
    wordT  target;

    modport control (
        output instr, pc, rsValue, rtValue,
        input  result, branchTaken, target
    );

    modport execute (
        input  instr, pc, rsValue, rtValue,
        output result, branchTaken, target
    );

endinterface

/* hdl/mipsExecute.sv */
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsExecute (
    mipsExecIf.execute exec
);
    import mipsPkg::*;

    wordT immSext;
    wordT immZext;
    wordT pcPlus4;
    wordT branchTarget;
    wordT jumpTarget;
    logic isJr;

    assign immSext = {{16{exec.instr.i.imm[15]}}, exec.instr.i.imm};
    assign immZext = {16'b0, exec.instr.i.imm};
    assign pcPlus4 = exec.pc + 32'd4;
    assign branchTarget = pcPlus4 + (immSext << 2);
    assign jumpTarget = {pcPlus4[`MIPS_WORD_W-1 -: 4], exec.instr.i.rs, exec.instr.i.rt,
                         exec.instr.i.imm, 2'b00};
    assign isJr = (exec.instr.r.opcode == OP_SPECIAL) && (exec.instr.r.funct == FN_JR);

    // ALU and effective address
    always_comb begin
        exec.result = '0;
        case (exec.instr.i.opcode)
            OP_SPECIAL: begin
                case (exec.instr.r.funct)
                    FN_ADDU: exec.result = exec.rsValue + exec.rtValue;
                    FN_SUBU: exec.result = exec.rsValue - exec.rtValue;
                    FN_AND:  exec.result = exec.rsValue & exec.rtValue;
                    FN_OR:   exec.result = exec.rsValue | exec.rtValue;
                    FN_XOR:  exec.result = exec.rsValue ^ exec.rtValue;
                    FN_SLT:  exec.result = wordT'($signed(exec.rsValue) < $signed(exec.rtValue));
                    FN_SLTU: exec.result = wordT'(exec.rsValue < exec.rtValue);
                    FN_SLL:  exec.result = exec.rtValue << exec.instr.r.shamt;
                    FN_SRL:  exec.result = exec.rtValue >> exec.instr.r.shamt;
                    FN_SRA:  exec.result = $signed(exec.rtValue) >>> exec.instr.r.shamt;
                    default: exec.result = '0;
                endcase
            end
            OP_ADDIU, OP_LW, OP_SW: exec.result = exec.rsValue + immSext;
            OP_SLTI:  exec.result = wordT'($signed(exec.rsValue) < $signed(immSext));
            // Unsigned compare against the sign-extended immediate
            OP_SLTIU: exec.result = wordT'(exec.rsValue < immSext);
            OP_ANDI:  exec.result = exec.rsValue & immZext;
            OP_ORI:   exec.result = exec.rsValue | immZext;
            OP_XORI:  exec.result = exec.rsValue ^ immZext;
            OP_LUI:   exec.result = {exec.instr.i.imm, 16'b0};
            default:  exec.result = '0;
        endcase
    end

    // Branch decision and target
    always_comb begin
        case (exec.instr.i.opcode)
            OP_BEQ: begin
                exec.branchTaken = (exec.rsValue == exec.rtValue);
                exec.target      = branchTarget;
            end
            OP_BNE: begin
                exec.branchTaken = (exec.rsValue != exec.rtValue);
                exec.target      = branchTarget;
            end
            OP_J: begin
                exec.branchTaken = 1'b1;
                exec.target      = jumpTarget;
            end
            default: begin
                exec.branchTaken = isJr;
                exec.target      = exec.rsValue;
            end
        endcase
    end

endmodule

/* hdl/mipsPkg.sv */
`include "mips_macros.svh"

package mipsPkg;

    typedef logic [`MIPS_WORD_W-1:0] wordT;
    typedef logic [$clog2(`MIPS_REG_COUNT)-1:0] regAddrT;

    // Primary opcodes kept in this core
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'd0,
        OP_J       = 6'd2,
        OP_BEQ     = 6'd4,
        OP_BNE     = 6'd5,
        OP_ADDIU   = 6'd9,
        OP_SLTI    = 6'd10,
        OP_SLTIU   = 6'd11,
        OP_ANDI    = 6'd12,
        OP_ORI     = 6'd13,
        OP_XORI    = 6'd14,
        OP_LUI     = 6'd15,
        OP_LW      = 6'd35,
        OP_SW      = 6'd43
    } opcodeT;

    // SPECIAL function codes
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } functT;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK,
        HALTED
    } cpuStateT;

    typedef struct packed {
        opcodeT      opcode;
        regAddrT     rs;
        regAddrT     rt;
        regAddrT     rd;
        logic [4:0]  shamt;
        functT       funct;
    } rViewT;

    // Jump target is {rs, rt, imm} of this view
    typedef struct packed {
        opcodeT      opcode;
        regAddrT     rs;
        regAddrT     rt;
        logic [15:0] imm;
    } iViewT;

    typedef union packed {
        rViewT r;
        iViewT i;
    } instrT;

endpackage

/* hdl/mipsRegFile.sv */
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsRegFile (
    input  logic            clk,
    input  logic            reset,
    input  mipsPkg::regAddrT rsAddr,
    input  mipsPkg::regAddrT rtAddr,
    output mipsPkg::wordT   rsData,
    output mipsPkg::wordT   rtData,
    input  logic            writeEn,
    input  mipsPkg::regAddrT writeAddr,
    input  mipsPkg::wordT   writeData,
    output mipsPkg::wordT   registerV0
);
    import mipsPkg::*;

    wordT regs [`MIPS_REG_COUNT];

    // Register zero is never written so it always reads as zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    assign rsData     = regs[rsAddr];
    assign rtData     = regs[rtAddr];
    assign registerV0 = regs[2];

endmodule

/* hdl/mips_macros.svh */
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// First instruction fetched after reset
`define MIPS_RESET_VECTOR 32'hBFC00000

// Jump or branch target that stops the CPU
`define MIPS_HALT_ADDR 32'h00000000

// Data and address width
`define MIPS_WORD_W 32

// Number of general registers
`define MIPS_REG_COUNT 32

`endif

/* verification/mipsCpuBusTb.sv */
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsCpuBusTb;
    import mipsPkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int NUM_TESTS   = 20;
    localparam int PROG_LEN    = 24;
    localparam int WATCHDOG_NS = NUM_TESTS * PROG_LEN * 8 * CLK_PERIOD * 2;

    logic clk;
    logic reset;
    logic active;
    wordT registerV0;
    wordT address;
    logic write;
    logic read;
    logic waitrequest;
    wordT writedata;
    logic [`MIPS_WORD_W/8-1:0] byteenable;
    wordT readdata;

    // Memories hold words as they appear on the bus
    wordT mem [wordT];
    wordT modelMem [wordT];
    wordT prog [PROG_LEN];
    wordT modelRegs [`MIPS_REG_COUNT];
    wordT expAddr [$];
    wordT expData [$];
    wordT gotAddr [$];
    wordT gotData [$];
    // Fetch and load addresses in bus order
    wordT expReads [$];
    wordT gotReads [$];
    wordT modelV0;
    int   errors;
    int   passed;

    mipsCpuBus uut (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .registerV0  (registerV0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the CPU did not halt within %0d ns", WATCHDOG_NS);
        $display("** FAIL **");
        $finish;
    end

    function automatic wordT reverseBytes(input wordT w);
        wordT r;
        for (int b = 0; b < 4; b++) begin
            r[8*b +: 8] = w[8*(3-b) +: 8];
        end
        return r;
    endfunction

    // Unwritten words return a pattern of their own address
    function automatic wordT fillWord(input wordT a);
        return {a[15:0], a[31:16]} ^ 32'hC3A5_5A3C;
    endfunction

    function automatic wordT modelRead(input wordT a);
        return modelMem.exists(a) ? modelMem[a] : fillWord(a);
    endfunction

    function automatic void setReg(input logic [4:0] idx, input wordT v);
        if (idx != 5'd0) begin
            modelRegs[idx] = v;
        end
    endfunction

    task automatic checkWord(input string name, input wordT got, input wordT exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkLogic(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Slave with 0 to 3 wait cycles per transfer
    initial begin : busResponder
        int   waitLeft;
        logic busy;
        busy = 1'b0;
        waitLeft = 0;
        forever begin
            @(negedge clk);
            if (read || write) begin
                if (!busy) begin
                    busy = 1'b1;
                    waitLeft = $urandom % 4;
                end
                if (waitLeft > 0) begin
                    waitrequest = 1'b1;
                    waitLeft--;
                end else begin
                    waitrequest = 1'b0;
                    busy = 1'b0;
                    if (read) begin
                        readdata = mem.exists(address) ? mem[address] : fillWord(address);
                        gotReads.push_back(address);
                    end else begin
                        mem[address] = writedata;
                        gotAddr.push_back(address);
                        gotData.push_back(writedata);
                    end
                end
            end else begin
                waitrequest = 1'b0;
                busy = 1'b0;
            end
        end
    end

    function automatic logic [4:0] randReg(input int span);
        return 5'($urandom % span);
    endfunction

    function automatic functT pickFunct();
        case ($urandom % 10)
            0: return FN_ADDU;
            1: return FN_SUBU;
            2: return FN_AND;
            3: return FN_OR;
            4: return FN_XOR;
            5: return FN_SLT;
            6: return FN_SLTU;
            7: return FN_SLL;
            8: return FN_SRL;
            default: return FN_SRA;
        endcase
    endfunction

    function automatic opcodeT pickImmOp();
        case ($urandom % 7)
            0: return OP_ADDIU;
            1: return OP_SLTI;
            2: return OP_SLTIU;
            3: return OP_ANDI;
            4: return OP_ORI;
            5: return OP_XORI;
            default: return OP_LUI;
        endcase
    endfunction

    // Forward branches only, never in a delay slot, end with JR $0 and a NOP
    task automatic buildProgram();
        logic noBranch;
        int   kind;
        int   room;
        int   skip;
        wordT target;
        noBranch = 1'b0;
        for (int i = 0; i < PROG_LEN - 2; i++) begin
            kind = $urandom % 10;
            if (noBranch || i > PROG_LEN - 4) begin
                kind = kind % 7;
            end
            noBranch = kind >= 7;
            room = PROG_LEN - 3 - i;
            if (room > 3) begin
                room = 3;
            end else if (room < 1) begin
                room = 1;
            end
            skip = 1 + $urandom % room;
            target = `MIPS_RESET_VECTOR + 4 * (i + 1 + skip);
            case (kind)
                0, 1, 2: prog[i] = {OP_SPECIAL, randReg(8), randReg(8), randReg(8),
                                    5'($urandom % 32), pickFunct()};
                3, 4: prog[i] = {pickImmOp(), randReg(8), randReg(8), 16'($urandom)};
                5: prog[i] = {OP_LW, 5'd0, randReg(8), 16'h1000 + 16'(4 * ($urandom % 8))};
                6: prog[i] = {OP_SW, 5'd0, randReg(8), 16'h1000 + 16'(4 * ($urandom % 8))};
                7: prog[i] = {OP_BEQ, randReg(4), randReg(4), 16'(skip)};
                8: prog[i] = {OP_BNE, randReg(4), randReg(4), 16'(skip)};
                default: prog[i] = {OP_J, target[27:2]};
            endcase
        end
        prog[PROG_LEN-2] = {OP_SPECIAL, 5'd0, 5'd0, 5'd0, 5'd0, FN_JR};
        prog[PROG_LEN-1] = '0;
        mem.delete();
        for (int i = 0; i < PROG_LEN; i++) begin
            mem[`MIPS_RESET_VECTOR + 4 * i] = reverseBytes(prog[i]);
        end
    endtask

    // Instruction-level reference with one delay slot
    task automatic runModel(output int steps, output bit halted);
        wordT pc;
        wordT w;
        wordT a;
        wordT b;
        wordT se;
        wordT ze;
        wordT pendTarget;
        wordT newTarget;
        logic pending;
        logic newPending;
        modelMem.delete();
        expAddr.delete();
        expData.delete();
        expReads.delete();
        for (int r = 0; r < `MIPS_REG_COUNT; r++) begin
            modelRegs[r] = '0;
        end
        pc = `MIPS_RESET_VECTOR;
        pending = 1'b0;
        pendTarget = '0;
        halted = 1'b0;
        steps = 0;
        while (!halted && steps <= PROG_LEN) begin
            expReads.push_back(pc);
            w = prog[(pc - `MIPS_RESET_VECTOR) >> 2];
            a = modelRegs[w[25:21]];
            b = modelRegs[w[20:16]];
            se = {{16{w[15]}}, w[15:0]};
            ze = {16'h0000, w[15:0]};
            newPending = 1'b0;
            newTarget = '0;
            case (w[31:26])
                OP_SPECIAL: begin
                    case (w[5:0])
                        FN_ADDU: setReg(w[15:11], a + b);
                        FN_SUBU: setReg(w[15:11], a - b);
                        FN_AND:  setReg(w[15:11], a & b);
                        FN_OR:   setReg(w[15:11], a | b);
                        FN_XOR:  setReg(w[15:11], a ^ b);
                        FN_SLT:  setReg(w[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                        FN_SLTU: setReg(w[15:11], (a < b) ? 32'd1 : 32'd0);
                        FN_SLL:  setReg(w[15:11], b << w[10:6]);
                        FN_SRL:  setReg(w[15:11], b >> w[10:6]);
                        FN_SRA:  setReg(w[15:11], $signed(b) >>> w[10:6]);
                        FN_JR: begin
                            newPending = 1'b1;
                            newTarget = a;
                        end
                        default: ;
                    endcase
                end
                OP_ADDIU: setReg(w[20:16], a + se);
                OP_SLTI:  setReg(w[20:16], ($signed(a) < $signed(se)) ? 32'd1 : 32'd0);
                OP_SLTIU: setReg(w[20:16], (a < se) ? 32'd1 : 32'd0);
                OP_ANDI:  setReg(w[20:16], a & ze);
                OP_ORI:   setReg(w[20:16], a | ze);
                OP_XORI:  setReg(w[20:16], a ^ ze);
                OP_LUI:   setReg(w[20:16], {w[15:0], 16'h0000});
                OP_LW: begin
                    expReads.push_back(a + se);
                    setReg(w[20:16], reverseBytes(modelRead(a + se)));
                end
                OP_SW: begin
                    modelMem[a + se] = reverseBytes(b);
                    expAddr.push_back(a + se);
                    expData.push_back(reverseBytes(b));
                end
                OP_BEQ, OP_BNE: begin
                    newPending = (w[31:26] == OP_BEQ) ? (a == b) : (a != b);
                    newTarget = pc + 32'd4 + (se << 2);
                end
                OP_J: begin
                    newPending = 1'b1;
                    newTarget = pc + 32'd4;
                    newTarget = {newTarget[31:28], w[25:0], 2'b00};
                end
                default: ;
            endcase
            steps++;
            if (pending && pendTarget == `MIPS_HALT_ADDR) begin
                halted = 1'b1;
            end else begin
                pc = pending ? pendTarget : pc + 32'd4;
            end
            pending = newPending;
            pendTarget = newTarget;
        end
        modelV0 = modelRegs[2];
    endtask

    task automatic runTest(input int num);
        int startErrors;
        int steps;
        bit halted;
        startErrors = errors;
        buildProgram();
        runModel(steps, halted);
        if (!halted) begin
            errors++;
            $display("Test %0d: the reference model ran off the program", num);
        end
        gotAddr.delete();
        gotData.delete();
        gotReads.delete();
        @(negedge clk);
        reset = 1'b1;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        checkLogic("read", read, 1'b1);
        checkWord("address", address, `MIPS_RESET_VECTOR);
        checkLogic("active", active, 1'b1);
        while (active) begin
            @(negedge clk);
        end
        checkWord("registerV0", registerV0, modelV0);
        if (gotAddr.size() != expAddr.size()) begin
            errors++;
            $display("Test %0d: %0d bus writes seen but %0d stores expected",
                     num, gotAddr.size(), expAddr.size());
        end
        for (int s = 0; s < gotAddr.size() && s < expAddr.size(); s++) begin
            checkWord("store address", gotAddr[s], expAddr[s]);
            checkWord("writedata", gotData[s], expData[s]);
        end
        // Reads taken while reset was held all hit the reset vector
        while (gotReads.size() > 1 && gotReads[0] == `MIPS_RESET_VECTOR &&
               gotReads[1] == `MIPS_RESET_VECTOR) begin
            void'(gotReads.pop_front());
        end
        if (gotReads.size() != expReads.size()) begin
            errors++;
            $display("Test %0d: %0d bus reads seen but %0d expected",
                     num, gotReads.size(), expReads.size());
        end
        for (int s = 0; s < gotReads.size() && s < expReads.size(); s++) begin
            checkWord("read address", gotReads[s], expReads[s]);
        end
        // Bus stays idle once halted
        repeat (4) begin
            @(negedge clk);
            checkLogic("read", read, 1'b0);
            checkLogic("write", write, 1'b0);
        end
        if (errors == startErrors) begin
            passed++;
        end
        $display("Test %0d: %s, %0d instructions, %0d stores", num,
                 (errors == startErrors) ? "ok" : "mismatch", steps, expAddr.size());
    endtask

    initial begin
        void'($urandom(92));
        reset = 1'b1;
        waitrequest = 1'b0;
        readdata = '0;
        errors = 0;
        passed = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            runTest(t);
        end
        if (uut.busChecks.violations != 0) begin
            errors++;
            $display("Bus protocol assertions failed %0d times", uut.busChecks.violations);
        end
        $display("Done: %0d of %0d tests passed, %0d failed checks", passed, NUM_TESTS, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* verification/mipsCpuBus_assertions.sv */
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsCpuBusAssertions (
    input logic                      clk,
    input logic                      reset,
    input logic                      active,
    input mipsPkg::wordT             address,
    input logic                      write,
    input logic                      read,
    input logic                      waitrequest,
    input logic [`MIPS_WORD_W/8-1:0] byteenable
);
    int violations;

    initial violations = 0;

    // Only full-word transfers in this core
    byteEnableFull: assert property (@(posedge clk) disable iff (reset) byteenable == '1)
        else begin
            violations++;
            $error("byteenable is not all ones");
        end

    strobesExclusive: assert property (@(posedge clk) disable iff (reset) !(read && write))
        else begin
            violations++;
            $error("read and write high together");
        end

    // Transfer held until the slave drops waitrequest
    holdWhileWaiting: assert property (@(posedge clk) disable iff (reset)
        (waitrequest && (read || write)) |=>
            ($stable(address) && $stable(read) && $stable(write)))
        else begin
            violations++;
            $error("bus request changed while waitrequest was high");
        end

    quietWhenHalted: assert property (@(posedge clk) disable iff (reset)
        !active |-> (!read && !write))
        else begin
            violations++;
            $error("bus activity after the CPU halted");
        end

endmodule

bind mipsCpuBus mipsCpuBusAssertions busChecks (
    .clk         (clk),
    .reset       (reset),
    .active      (active),
    .address     (address),
    .write       (write),
    .read        (read),
    .waitrequest (waitrequest),
    .byteenable  (byteenable)
);

/* vlog.f */
+incdir+hdl
hdl/mipsPkg.sv
hdl/mipsExecIf.sv
hdl/mipsRegFile.sv
hdl/mipsExecute.sv
hdl/mipsControl.sv
hdl/mipsCpuBus.sv
verification/mipsCpuBus_assertions.sv
verification/mipsCpuBusTb.sv
